// File: hdl/mem_pkg.sv
`default_nettype none

package mem_pkg;

    typedef logic [31:0] mem_addr_t;  // Byte address
    typedef logic [31:0] mem_data_t;
    typedef logic [1:0]  mem_size_t;
    typedef logic [3:0]  mem_strb_t;  // One enable per byte lane

    // Size code 3 is handled like a word everywhere
    localparam mem_size_t SIZE_BYTE = 2'd0;
    localparam mem_size_t SIZE_HALF = 2'd1;
    localparam mem_size_t SIZE_WORD = 2'd2;

    localparam mem_addr_t RAM_BASE = 32'h0000_0000;
    localparam mem_addr_t FB_BASE  = 32'h0300_0000;

    typedef logic [3:0] bist_step_t;

    // Steps 0 to 7 land in main RAM and 8 to 14 in the frame buffer
    localparam int        BIST_STEPS  = 15;
    localparam mem_addr_t BIST_STRIDE = 32'h0000_0404;
    localparam mem_data_t BIST_KEY    = 32'h5A5A_A5A5;

    localparam logic [7:0] LED_RUN  = 8'hFF;
    localparam logic [7:0] LED_PASS = 8'h0F;
    localparam logic [7:0] LED_FAIL = 8'hF0;

    typedef enum logic [2:0] {
        WRITE,
        READ,
        CHECK,
        PASS,
        FAIL
    } bist_state_t;

endpackage : mem_pkg

`default_nettype wire

// File: hdl/mem_bank.sv
`timescale 1ns/1ns
`default_nettype none

module mem_bank #(
    parameter int DEPTH = 4096
) (
    input  wire logic                       GCLK,
    input  wire logic                       en,
    input  wire mem_pkg::mem_strb_t         we,
    input  wire logic [$clog2(DEPTH)-1:0]   addr,
    input  wire mem_pkg::mem_data_t         wdata,
    output mem_pkg::mem_data_t              rdata
);

    mem_pkg::mem_data_t mem [DEPTH];

    // Read returns the word as it was before any write in the same cycle
    always_ff @(posedge GCLK) begin
        if (en) begin
            for (int b = 0; b < 4; b++) begin
                if (we[b]) begin
                    mem[addr][b*8 +: 8] <= wdata[b*8 +: 8];
                end
            end
            rdata <= mem[addr];
        end
    end

endmodule : mem_bank

`default_nettype wire

// File: hdl/mem_bus_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module mem_bus_ctrl #(
    parameter int RAM_WORDS = 4096,
    parameter int FB_WORDS  = 2048
) (
    input  wire logic                           GCLK,
    input  wire logic                           BTND,
    input  wire logic                           bus_req,
    input  wire logic                           bus_write,
    input  wire mem_pkg::mem_addr_t             bus_addr,
    input  wire mem_pkg::mem_size_t             bus_size,
    input  wire mem_pkg::mem_data_t             bus_wdata,
    output mem_pkg::mem_data_t                  bus_rdata,
    output logic                                bus_pause,
    input  wire logic                           gfx_en,
    input  wire mem_pkg::mem_addr_t             gfx_addr,
    output mem_pkg::mem_data_t                  gfx_data,
    input  wire logic                           bist_active,
    input  wire logic                           bist_req,
    input  wire logic                           bist_write,
    input  wire mem_pkg::mem_addr_t             bist_addr,
    input  wire mem_pkg::mem_data_t             bist_wdata,
    output logic                                bist_pause,
    output mem_pkg::mem_data_t                  bist_rdata,
    output logic                                ram_en,
    output mem_pkg::mem_strb_t                  ram_we,
    output logic [$clog2(RAM_WORDS)-1:0]        ram_addr,
    output mem_pkg::mem_data_t                  ram_wdata,
    input  wire mem_pkg::mem_data_t             ram_rdata,
    output logic                                fb_en,
    output mem_pkg::mem_strb_t                  fb_we,
    output logic [$clog2(FB_WORDS)-1:0]         fb_addr,
    output mem_pkg::mem_data_t                  fb_wdata,
    input  wire mem_pkg::mem_data_t             fb_rdata
);

    localparam int          RAM_AW  = $clog2(RAM_WORDS);
    localparam int          FB_AW   = $clog2(FB_WORDS);
    localparam logic [21:0] RAM_LIM = 22'(RAM_WORDS);
    localparam logic [21:0] FB_LIM  = 22'(FB_WORDS);

    logic               m_req, m_write;
    mem_pkg::mem_addr_t m_addr;
    mem_pkg::mem_size_t m_size;
    mem_pkg::mem_data_t m_wdata;
    logic               m_ram_hit, m_fb_hit, gfx_hit;
    logic               collide, go;
    mem_pkg::mem_strb_t strb;
    mem_pkg::mem_data_t lanes;
    logic [1:0]         m_lane;
    logic               rd_pend, rd_ram, rd_fb;
    mem_pkg::mem_size_t rd_size;
    logic [1:0]         rd_lane;
    mem_pkg::mem_data_t rd_raw, rd_shift, rd_now, rd_hold;
    logic               gfx_pend, gfx_hit_q;
    mem_pkg::mem_data_t gfx_now, gfx_hold;

    // The self-test owns the bus until it reaches PASS or FAIL
    assign m_req   = bist_active ? bist_req   : bus_req;
    assign m_write = bist_active ? bist_write : bus_write;
    assign m_addr  = bist_active ? bist_addr  : bus_addr;
    assign m_size  = bist_active ? mem_pkg::SIZE_WORD : bus_size;
    assign m_wdata = bist_active ? bist_wdata : bus_wdata;

    assign m_ram_hit = (m_addr[31:24] == mem_pkg::RAM_BASE[31:24]) && (m_addr[23:2] < RAM_LIM);
    assign m_fb_hit  = (m_addr[31:24] == mem_pkg::FB_BASE[31:24]) && (m_addr[23:2] < FB_LIM);
    assign gfx_hit   = (gfx_addr[31:24] == mem_pkg::FB_BASE[31:24]) && (gfx_addr[23:2] < FB_LIM);

    // Graphics wins the frame buffer, the master waits
    assign collide    = m_req & m_fb_hit & gfx_en;
    assign go         = m_req & ~collide;
    assign bus_pause  = bist_active | collide;
    assign bist_pause = bist_active & collide;

    always_comb begin
        case (m_size)
            mem_pkg::SIZE_BYTE: begin
                strb   = mem_pkg::mem_strb_t'(4'b0001 << m_addr[1:0]);
                lanes  = {4{m_wdata[7:0]}};
                m_lane = m_addr[1:0];
            end
            mem_pkg::SIZE_HALF: begin
                strb   = m_addr[1] ? 4'b1100 : 4'b0011;
                lanes  = {2{m_wdata[15:0]}};
                m_lane = {m_addr[1], 1'b0};  // Aligned down to the halfword
            end
            default: begin
                strb   = 4'b1111;
                lanes  = m_wdata;
                m_lane = 2'd0;
            end
        endcase
    end

    assign ram_en    = go & m_ram_hit;
    assign ram_we    = (ram_en & m_write) ? strb : '0;
    assign ram_addr  = m_addr[RAM_AW+1:2];
    assign ram_wdata = lanes;

    assign fb_en    = (gfx_en & gfx_hit) | (go & m_fb_hit);
    assign fb_we    = (go & m_fb_hit & m_write) ? strb : '0;
    assign fb_addr  = gfx_en ? gfx_addr[FB_AW+1:2] : m_addr[FB_AW+1:2];
    assign fb_wdata = lanes;

    always_ff @(posedge GCLK, posedge BTND) begin
        if (BTND) begin
            rd_pend   <= 1'b0;
            rd_ram    <= 1'b0;
            rd_fb     <= 1'b0;
            rd_size   <= mem_pkg::SIZE_WORD;
            rd_lane   <= 2'd0;
            rd_hold   <= '0;
            gfx_pend  <= 1'b0;
            gfx_hit_q <= 1'b0;
            gfx_hold  <= '0;
        end else begin
            rd_pend <= go & ~m_write;
            if (go & ~m_write) begin
                rd_ram  <= m_ram_hit;
                rd_fb   <= m_fb_hit;
                rd_size <= m_size;
                rd_lane <= m_lane;
            end
            if (rd_pend) begin
                rd_hold <= rd_now;  // Keeps the result after the bank moves on
            end
            gfx_pend <= gfx_en;
            if (gfx_en) begin
                gfx_hit_q <= gfx_hit;
            end
            if (gfx_pend) begin
                gfx_hold <= gfx_now;
            end
        end
    end

    // Unmapped reads fall through to zero
    always_comb begin
        if (rd_ram) begin
            rd_raw = ram_rdata;
        end else if (rd_fb) begin
            rd_raw = fb_rdata;
        end else begin
            rd_raw = '0;
        end
        rd_shift = rd_raw >> {rd_lane, 3'b000};
        case (rd_size)
            mem_pkg::SIZE_BYTE: rd_now = {24'd0, rd_shift[7:0]};
            mem_pkg::SIZE_HALF: rd_now = {16'd0, rd_shift[15:0]};
            default:            rd_now = rd_raw;
        endcase
    end

    assign bus_rdata  = rd_pend ? rd_now : rd_hold;
    assign bist_rdata = bus_rdata;

    assign gfx_now  = gfx_hit_q ? fb_rdata : '0;
    assign gfx_data = gfx_pend ? gfx_now : gfx_hold;

endmodule : mem_bus_ctrl

`default_nettype wire

// File: hdl/bist_fsm.sv
`timescale 1ns/1ns
`default_nettype none

module bist_fsm (
    input  wire logic               GCLK,
    input  wire logic               BTND,
    input  wire logic               bist_pause,
    input  wire mem_pkg::mem_data_t bist_rdata,
    input  wire mem_pkg::mem_data_t bist_wdata,
    input  wire logic               step_last,
    output logic                    bist_active,
    output logic                    bist_req,
    output logic                    bist_write,
    output logic                    step_adv,
    output logic                    step_clr,
    output logic [7:0]              LD
);

    mem_pkg::bist_state_t state, state_next;

    always_ff @(posedge GCLK, posedge BTND) begin
        if (BTND) begin
            state <= mem_pkg::WRITE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        step_adv   = 1'b0;
        step_clr   = 1'b0;
        case (state)
            mem_pkg::WRITE: begin
                if (!bist_pause) begin
                    if (step_last) begin
                        step_clr   = 1'b1;  // Read-back starts again at step 0
                        state_next = mem_pkg::READ;
                    end else begin
                        step_adv = 1'b1;
                    end
                end
            end
            mem_pkg::READ: begin
                if (!bist_pause) begin
                    state_next = mem_pkg::CHECK;
                end
            end
            mem_pkg::CHECK: begin
                // The counter has not moved since READ so bist_wdata is still the expected word
                if (bist_rdata != bist_wdata) begin
                    state_next = mem_pkg::FAIL;
                end else if (step_last) begin
                    state_next = mem_pkg::PASS;
                end else begin
                    step_adv   = 1'b1;
                    state_next = mem_pkg::READ;
                end
            end
            default: begin
                state_next = state;  // PASS and FAIL hold until reset
            end
        endcase
    end

    assign bist_active = (state == mem_pkg::WRITE) || (state == mem_pkg::READ) ||
                         (state == mem_pkg::CHECK);
    assign bist_req    = (state == mem_pkg::WRITE) || (state == mem_pkg::READ);
    assign bist_write  = (state == mem_pkg::WRITE);

    always_comb begin
        case (state)
            mem_pkg::PASS: LD = mem_pkg::LED_PASS;
            mem_pkg::FAIL: LD = mem_pkg::LED_FAIL;
            default:       LD = mem_pkg::LED_RUN;
        endcase
    end

endmodule : bist_fsm

`default_nettype wire

// File: hdl/bist_counter.sv
`timescale 1ns/1ns
`default_nettype none

module bist_counter (
    input  wire logic        GCLK,
    input  wire logic        BTND,
    input  wire logic        step_adv,
    input  wire logic        step_clr,
    output mem_pkg::mem_addr_t bist_addr,
    output mem_pkg::mem_data_t bist_wdata,
    output logic             step_last
);

    mem_pkg::bist_step_t step;
    mem_pkg::bist_step_t idx;
    mem_pkg::mem_addr_t  offset;
    logic                in_fb;

    // Clear wins over advance
    always_ff @(posedge GCLK, posedge BTND) begin
        if (BTND) begin
            step <= '0;
        end else if (step_clr) begin
            step <= '0;
        end else if (step_adv) begin
            step <= step + 4'd1;
        end
    end

    // The upper steps index into the frame buffer from its own base
    assign in_fb  = (step >= 4'd8);
    assign idx    = in_fb ? (step - 4'd8) : step;
    assign offset = {28'd0, idx} * mem_pkg::BIST_STRIDE;

    assign bist_addr  = (in_fb ? mem_pkg::FB_BASE : mem_pkg::RAM_BASE) + offset;
    assign bist_wdata = bist_addr ^ mem_pkg::BIST_KEY;

    assign step_last = (step == mem_pkg::bist_step_t'(mem_pkg::BIST_STEPS - 1));

endmodule : bist_counter

`default_nettype wire

// File: hdl/mem_top.sv
`timescale 1ns/1ns
`default_nettype none

module mem_top #(
    parameter int RAM_WORDS = 4096,  // 16 KB
    parameter int FB_WORDS  = 2048   // 8 KB
) (
    input  wire logic               GCLK,
    input  wire logic               BTND,
    input  wire logic               bus_req,
    input  wire logic               bus_write,
    input  wire mem_pkg::mem_addr_t bus_addr,
    input  wire mem_pkg::mem_size_t bus_size,
    input  wire mem_pkg::mem_data_t bus_wdata,
    output mem_pkg::mem_data_t      bus_rdata,
    output logic                    bus_pause,
    input  wire logic               gfx_en,
    input  wire mem_pkg::mem_addr_t gfx_addr,
    output mem_pkg::mem_data_t      gfx_data,
    output logic [7:0]              LD
);

    logic                           bist_active, bist_req, bist_write, bist_pause;
    mem_pkg::mem_addr_t             bist_addr;
    mem_pkg::mem_data_t             bist_wdata, bist_rdata;
    logic                           step_adv, step_clr, step_last;

    logic                           ram_en, fb_en;
    mem_pkg::mem_strb_t             ram_we, fb_we;
    logic [$clog2(RAM_WORDS)-1:0]   ram_addr;
    logic [$clog2(FB_WORDS)-1:0]    fb_addr;
    mem_pkg::mem_data_t             ram_wdata, ram_rdata, fb_wdata, fb_rdata;

    mem_bus_ctrl #(
        .RAM_WORDS (RAM_WORDS),
        .FB_WORDS  (FB_WORDS)
    ) u_ctrl (
        .GCLK, .BTND,
        .bus_req, .bus_write, .bus_addr, .bus_size, .bus_wdata, .bus_rdata, .bus_pause,
        .gfx_en, .gfx_addr, .gfx_data,
        .bist_active, .bist_req, .bist_write, .bist_addr, .bist_wdata,
        .bist_pause, .bist_rdata,
        .ram_en, .ram_we, .ram_addr, .ram_wdata, .ram_rdata,
        .fb_en, .fb_we, .fb_addr, .fb_wdata, .fb_rdata
    );

    mem_bank #(.DEPTH(RAM_WORDS)) u_ram (
        .GCLK,
        .en    (ram_en),
        .we    (ram_we),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

    // Shared between the graphics port and the bus, graphics first
    mem_bank #(.DEPTH(FB_WORDS)) u_fb (
        .GCLK,
        .en    (fb_en),
        .we    (fb_we),
        .addr  (fb_addr),
        .wdata (fb_wdata),
        .rdata (fb_rdata)
    );

    bist_fsm u_bist_fsm (
        .GCLK, .BTND,
        .bist_pause, .bist_rdata, .bist_wdata, .step_last,
        .bist_active, .bist_req, .bist_write, .step_adv, .step_clr,
        .LD
    );

    bist_counter u_bist_cnt (
        .GCLK, .BTND,
        .step_adv, .step_clr,
        .bist_addr, .bist_wdata, .step_last
    );

endmodule : mem_top

`default_nettype wire

// File: verif/mem_bus_props.sv
`timescale 1ns/1ns
`default_nettype none

module mem_bus_props #(
    parameter int FB_WORDS = 2048
) (
    input wire logic               GCLK,
    input wire logic               BTND,
    input wire logic               bist_active,
    input wire logic               bus_req,
    input wire mem_pkg::mem_addr_t bus_addr,
    input wire logic               gfx_en,
    input wire logic               bus_pause,
    input wire mem_pkg::mem_strb_t ram_we,
    input wire mem_pkg::mem_strb_t fb_we
);

    localparam logic [21:0] FB_LIM = 22'(FB_WORDS);

    logic bus_fb_hit;

    assign bus_fb_hit = (bus_addr[31:24] == 8'h03) && (bus_addr[23:2] < FB_LIM);

    // The self-test holds the bus only from reset until it ends
    a_pause_in_bist: assert property (@(posedge GCLK) disable iff (BTND)
        bist_active |-> (bus_pause && $past(bist_active)))
        else $error("bus_pause low during the self-test or the self-test restarted");

    // A paused CPU request must leave both banks untouched
    a_no_paused_write: assert property (@(posedge GCLK) disable iff (BTND)
        (!bist_active && bus_pause) |-> (ram_we == '0 && fb_we == '0))
        else $error("bank written while the CPU bus is paused");

    a_pause_cause: assert property (@(posedge GCLK) disable iff (BTND)
        bus_pause |-> (bist_active || (bus_req && gfx_en && bus_fb_hit)))
        else $error("bus_pause high without self-test or frame buffer collision");

endmodule : mem_bus_props

bind mem_bus_ctrl mem_bus_props #(.FB_WORDS(FB_WORDS)) u_props (
    .GCLK(GCLK), .BTND(BTND), .bist_active(bist_active), .bus_req(bus_req),
    .bus_addr(bus_addr), .gfx_en(gfx_en), .bus_pause(bus_pause),
    .ram_we(ram_we), .fb_we(fb_we)
);

`default_nettype wire

// File: verif/mem_tb.sv
`timescale 1ns/1ns
`default_nettype none

module mem_tb;

    localparam int RAM_WORDS  = 4096;
    localparam int FB_WORDS   = 2048;
    localparam int CLK_PERIOD = 4;
    localparam int N_OPS      = 400;
    localparam int BIST_BOUND = 300;  // Self-test cycles allowed with graphics traffic
    localparam int WD_CYCLES  = 4 + BIST_BOUND + (N_OPS + mem_pkg::BIST_STEPS) * 8;

    logic               GCLK, BTND, bus_req, bus_write, bus_pause, gfx_en;
    mem_pkg::mem_addr_t bus_addr, gfx_addr;
    mem_pkg::mem_size_t bus_size;
    mem_pkg::mem_data_t bus_wdata, bus_rdata, gfx_data, last_rd;
    logic [7:0]         LD;
    logic [7:0]         model [mem_pkg::mem_addr_t];  // Byte-wide reference memory
    mem_pkg::mem_addr_t bist_addrs [mem_pkg::BIST_STEPS];

    mem_top #(.RAM_WORDS(RAM_WORDS), .FB_WORDS(FB_WORDS)) dut (.*);

    always #(CLK_PERIOD / 2) GCLK = ~GCLK;

    function automatic logic in_fb(input mem_pkg::mem_addr_t a);
        return a[31:24] == 8'h03 && int'({10'd0, a[23:2]}) < FB_WORDS;
    endfunction

    function automatic logic is_mapped(input mem_pkg::mem_addr_t a);
        return in_fb(a) || (a[31:24] == 8'h00 && int'({10'd0, a[23:2]}) < RAM_WORDS);
    endfunction

    // Size code 3 counts as a word
    function automatic int size_bytes(input mem_pkg::mem_size_t s);
        return (s == mem_pkg::SIZE_BYTE) ? 1 : (s == mem_pkg::SIZE_HALF) ? 2 : 4;
    endfunction

    function automatic mem_pkg::mem_data_t model_read(input mem_pkg::mem_addr_t a,
                                                      input mem_pkg::mem_size_t s);
        mem_pkg::mem_addr_t base;
        mem_pkg::mem_data_t d;
        base = a & ~mem_pkg::mem_addr_t'(size_bytes(s) - 1);  // Align down to the size
        d = '0;
        for (int b = 0; b < size_bytes(s); b++) begin
            if (is_mapped(a) && model.exists(base + b)) begin
                d[b*8 +: 8] = model[base + b];
            end
        end
        return d;
    endfunction

    function automatic void model_write(input mem_pkg::mem_addr_t a, input mem_pkg::mem_size_t s,
                                        input mem_pkg::mem_data_t d);
        mem_pkg::mem_addr_t base;
        base = a & ~mem_pkg::mem_addr_t'(size_bytes(s) - 1);
        if (is_mapped(a)) begin
            for (int b = 0; b < size_bytes(s); b++) begin
                model[base + b] = d[b*8 +: 8];
            end
        end
    endfunction

    task automatic check_data(input mem_pkg::mem_data_t got, input mem_pkg::mem_data_t exp,
                              input string what);
        if (got !== exp) begin
            $display("FAIL %0t ns: %s returned %h, expected %h", $time, what, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "Data mismatch");
        end
    endtask

    task automatic check_leds(input logic [7:0] got, input logic [7:0] exp, input string what);
        if (got !== exp) begin
            $display("FAIL %0t ns: %s show %h, expected %h", $time, what, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "LED mismatch");
        end
    endtask

    task automatic check_pause(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("FAIL %0t ns: %s is %b, expected %b", $time, what, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "Pause mismatch");
        end
    endtask

    // One bus access with an optional graphics read in the same cycle
    task automatic run_op(input logic wr, input mem_pkg::mem_addr_t addr,
                          input mem_pkg::mem_size_t size, input mem_pkg::mem_data_t wdata,
                          input logic g_en, input mem_pkg::mem_addr_t g_addr);
        mem_pkg::mem_data_t exp_rd, exp_gfx;
        logic               coll;
        @(posedge GCLK);
        bus_req   <= 1'b1;
        bus_write <= wr;
        bus_addr  <= addr;
        bus_size  <= size;
        bus_wdata <= wdata;
        gfx_en    <= g_en;
        gfx_addr  <= g_addr;
        @(negedge GCLK);
        coll    = g_en && in_fb(addr);
        exp_gfx = in_fb(g_addr) ? model_read(g_addr, mem_pkg::SIZE_WORD) : '0;
        check_pause(bus_pause, coll, "bus_pause with a request pending");
        if (coll) begin
            @(posedge GCLK);
            gfx_en <= 1'b0;  // Graphics backs off so the held request can go
            @(negedge GCLK);
            check_data(gfx_data, exp_gfx, "graphics read during collision");
            check_pause(bus_pause, 1'b0, "bus_pause after graphics released");
        end
        @(posedge GCLK);
        exp_rd = model_read(addr, size);
        if (wr) begin
            model_write(addr, size, wdata);
        end
        bus_req <= 1'b0;
        gfx_en  <= 1'b0;
        @(negedge GCLK);
        if (wr) begin
            check_data(bus_rdata, last_rd, "bus read data held across a write");
        end else begin
            check_data(bus_rdata, exp_rd, "bus read");
            last_rd = exp_rd;
        end
        if (g_en && !coll) begin
            check_data(gfx_data, exp_gfx, "graphics read");
        end
    endtask

    task automatic random_op();
        mem_pkg::mem_addr_t off, addr, g_addr;
        int                 region;
        off    = mem_pkg::mem_addr_t'($urandom % 128);
        region = int'($urandom % 8);
        case (region)
            0, 1, 2: addr = mem_pkg::RAM_BASE + off;
            3, 4, 5: addr = mem_pkg::FB_BASE + off;
            6:       addr = (off[0] ? 32'h0000_4000 : 32'h0300_2000) + off;  // Just past a region
            default: addr = $urandom;
        endcase
        g_addr = (($urandom % 4) == 0 ? mem_pkg::RAM_BASE : mem_pkg::FB_BASE) +
                 mem_pkg::mem_addr_t'($urandom % 128);
        run_op(($urandom % 2) == 1, addr, mem_pkg::mem_size_t'($urandom % 4), $urandom,
               ($urandom % 3) == 0, g_addr);
    endtask

    initial begin
        void'($urandom(32'h5d189636));
        GCLK      = 1'b0;
        BTND      = 1'b1;
        bus_req   = 1'b0;
        bus_write = 1'b0;
        bus_addr  = '0;
        bus_size  = mem_pkg::SIZE_WORD;
        bus_wdata = '0;
        gfx_en    = 1'b0;
        gfx_addr  = '0;
        last_rd   = '0;
        for (int i = 0; i < mem_pkg::BIST_STEPS; i++) begin
            bist_addrs[i] = (i < 8) ?
                mem_pkg::RAM_BASE + mem_pkg::mem_addr_t'(i) * mem_pkg::BIST_STRIDE :
                mem_pkg::FB_BASE + mem_pkg::mem_addr_t'(i - 8) * mem_pkg::BIST_STRIDE;
            model_write(bist_addrs[i], mem_pkg::SIZE_WORD, bist_addrs[i] ^ mem_pkg::BIST_KEY);
        end
        repeat (4) @(posedge GCLK);
        BTND <= 1'b0;
        @(negedge GCLK);
        check_leds(LD, mem_pkg::LED_RUN, "LEDs after reset");
        check_data(bus_rdata, '0, "bus port after reset");
        check_data(gfx_data, '0, "graphics port after reset");
        // Graphics traffic keeps running until the self-test reports
        while (LD == mem_pkg::LED_RUN) begin
            check_pause(bus_pause, 1'b1, "bus_pause during self-test");
            @(posedge GCLK);
            gfx_en   <= ($urandom % 2) == 1;
            gfx_addr <= mem_pkg::FB_BASE + mem_pkg::mem_addr_t'($urandom % 8192);
            @(negedge GCLK);
        end
        check_leds(LD, mem_pkg::LED_PASS, "LEDs after self-test");
        for (int i = 0; i < mem_pkg::BIST_STEPS; i++) begin
            run_op(1'b0, bist_addrs[i], mem_pkg::SIZE_WORD, '0, 1'b0, '0);
            check_data(bus_rdata, bist_addrs[i] ^ mem_pkg::BIST_KEY, "self-test pattern");
        end
        repeat (N_OPS) random_op();
        check_leds(LD, mem_pkg::LED_PASS, "LEDs at end of run");
        $display("RESULT: PASS");
        $finish;
    end

    initial begin
        #(WD_CYCLES * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d clock cycles", WD_CYCLES);
        $display("RESULT: FAIL");
        $fatal(1, "Watchdog expired");
    end

endmodule : mem_tb

`default_nettype wire

// File: sources.f
hdl/mem_pkg.sv
hdl/mem_bank.sv
hdl/mem_bus_ctrl.sv
hdl/bist_fsm.sv
hdl/bist_counter.sv
hdl/mem_top.sv
verif/mem_bus_props.sv
verif/mem_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the memory subsystem testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
SIM_BIN=mem_tb_sim

verilator --binary --timing --assert -j 0 \
    --top-module mem_tb \
    -f sources.f \
    --Mdir "$OBJ_DIR" -o "$SIM_BIN"
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit $build_status
fi

"./$OBJ_DIR/$SIM_BIN"
sim_status=$?
if [ $sim_status -ne 0 ]; then
    echo "Simulation failed with status $sim_status"
    exit $sim_status
fi

echo "Simulation completed"
exit 0
